// File: include/raw_rgb_defines.svh
`ifndef RAW_RGB_DEFINES_SVH
`define RAW_RGB_DEFINES_SVH

`define RAW_RGB_PIX_W      10
`define RAW_RGB_MAX_X      64
`define RAW_RGB_X_W        6
`define RAW_RGB_COEFF_W    16
`define RAW_RGB_FRAC_W     8
`define RAW_RGB_OFS_W      12
`define RAW_RGB_ADR_W      4
`define RAW_RGB_DAT_W      16

`define RAW_RGB_REG_PHASE  0
`define RAW_RGB_REG_C00    1
`define RAW_RGB_REG_C01    2
`define RAW_RGB_REG_C02    3
`define RAW_RGB_REG_C10    4
`define RAW_RGB_REG_C11    5
`define RAW_RGB_REG_C12    6
`define RAW_RGB_REG_C20    7
`define RAW_RGB_REG_C21    8
`define RAW_RGB_REG_C22    9
`define RAW_RGB_REG_OFS_R  10
`define RAW_RGB_REG_OFS_G  11
`define RAW_RGB_REG_OFS_B  12

`endif

// File: hdl/raw_rgb_pkg.sv
`include "raw_rgb_defines.svh"

package raw_rgb_pkg;

	typedef logic [`RAW_RGB_PIX_W-1:0]          pixel_t;
	typedef logic signed [`RAW_RGB_COEFF_W-1:0] coeff_t;
	typedef logic signed [`RAW_RGB_OFS_W-1:0]   offset_t;
	typedef logic [1:0]                         phase_t;    // bit0 column flip, bit1 row flip
	typedef logic [`RAW_RGB_X_W-1:0]            xpos_t;
	typedef logic [`RAW_RGB_DAT_W-1:0]          reg_data_t;

	typedef struct packed {
		logic   valid;
		logic   frame_start;
		logic   line_last;
		logic   line_first;  // first line of the frame
		xpos_t  x;
		logic   y_odd;
		pixel_t raw;
	} raw_beat_t;

	typedef struct packed {
		logic   valid;
		logic   frame_start;
		logic   line_last;
		pixel_t raw;
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_beat_t;

	typedef struct packed {
		coeff_t  [0:2][0:2] coef;  // [row][col] with row 0 giving R
		offset_t [0:2]      ofs;   // R, G, B
	} coeff_set_t;

endpackage

// File: hdl/raw_rgb_regs.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module raw_rgb_regs
	import raw_rgb_pkg::*;
(
	input  logic                      aclk,
	input  logic                      arst_n_i,
	input  logic [`RAW_RGB_ADR_W-1:0] reg_adr_i,
	input  reg_data_t                 reg_dat_i,
	input  logic                      reg_we_i,
	input  logic                      reg_stb_i,
	output reg_data_t                 reg_dat_o,
	output logic                      reg_ack_o,
	output phase_t                    phase_o,
	output coeff_set_t                coeffs_o
);

	phase_t     phase_q;
	coeff_set_t coeffs_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phase_q <= '0;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					coeffs_q.coef[r][c] <= (r == c) ? coeff_t'(1 << `RAW_RGB_FRAC_W) : '0;
				end
				coeffs_q.ofs[r] <= '0;
			end
		end else if (reg_stb_i && reg_we_i) begin
			if (reg_adr_i == `RAW_RGB_REG_PHASE)
				phase_q <= reg_dat_i[1:0];
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					if (reg_adr_i == `RAW_RGB_REG_C00 + 3 * r + c)
						coeffs_q.coef[r][c] <= coeff_t'(reg_dat_i);
				end
				if (reg_adr_i == `RAW_RGB_REG_OFS_R + r)
					coeffs_q.ofs[r] <= reg_dat_i[`RAW_RGB_OFS_W-1:0];
			end
		end
	end

	always_comb begin
		reg_dat_o = '0;  // unmapped reads 0
		if (reg_adr_i == `RAW_RGB_REG_PHASE)
			reg_dat_o[1:0] = phase_q;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (reg_adr_i == `RAW_RGB_REG_C00 + 3 * r + c)
					reg_dat_o = reg_data_t'(coeffs_q.coef[r][c]);
			end
			if (reg_adr_i == `RAW_RGB_REG_OFS_R + r)
				reg_dat_o = reg_data_t'($signed(coeffs_q.ofs[r]));  // sign extended
		end
	end

	assign reg_ack_o = reg_stb_i;
	assign phase_o   = phase_q;
	assign coeffs_o  = coeffs_q;

endmodule

// File: hdl/raw_rgb_stream_ctl.sv
`timescale 1ns/1ps

module raw_rgb_stream_ctl
	import raw_rgb_pkg::*;
(
	input  logic      aclk,
	input  logic      arst_n_i,
	input  pixel_t    s_tdata_i,
	input  logic      s_tuser_i,
	input  logic      s_tlast_i,
	input  logic      s_tvalid_i,
	input  logic      m_tvalid_i,
	input  logic      m_tready_i,
	output logic      s_tready_o,
	output logic      cke_o,
	output raw_beat_t beat_o
);

	xpos_t     x_q;
	logic      y_odd_q;
	logic      first_q;
	xpos_t     cur_x;
	logic      cur_y;
	logic      cur_first;
	logic      accept;
	raw_beat_t beat_q;

	// whole pipeline stalls only when the output is held
	assign cke_o      = !m_tvalid_i || m_tready_i;
	assign s_tready_o = cke_o;
	assign accept     = s_tvalid_i && cke_o;

	// frame start forces the position back to the origin
	assign cur_x     = s_tuser_i ? '0   : x_q;
	assign cur_y     = s_tuser_i ? 1'b0 : y_odd_q;
	assign cur_first = s_tuser_i ? 1'b1 : first_q;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			x_q     <= '0;
			y_odd_q <= 1'b0;
			first_q <= 1'b1;
		end else if (accept) begin
			if (s_tlast_i) begin
				x_q     <= '0;
				y_odd_q <= !cur_y;
				first_q <= 1'b0;
			end else begin
				x_q     <= cur_x + 1'b1;
				y_odd_q <= cur_y;
				first_q <= cur_first;
			end
		end
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			beat_q.valid <= 1'b0;
		end else if (cke_o) begin
			beat_q.valid       <= s_tvalid_i;  // bubble when no input
			beat_q.frame_start <= s_tuser_i;
			beat_q.line_last   <= s_tlast_i;
			beat_q.line_first  <= cur_first;
			beat_q.x           <= cur_x;
			beat_q.y_odd       <= cur_y;
			beat_q.raw         <= s_tdata_i;
		end
	end

	assign beat_o = beat_q;

endmodule

// File: hdl/raw_rgb_demosaic.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module raw_rgb_demosaic
	import raw_rgb_pkg::*;
(
	input  logic      aclk,
	input  logic      arst_n_i,
	input  logic      cke_i,
	input  phase_t    phase_i,
	input  raw_beat_t beat_i,
	output rgb_beat_t beat_o
);

	pixel_t                   line_mem [`RAW_RGB_MAX_X];  // previous line
	pixel_t                   left_q;
	pixel_t                   up_q;
	pixel_t                   up_pix;
	pixel_t                   left_pix;
	pixel_t                   ul_pix;
	pixel_t [3:0]             samp;
	logic   [1:0]             cls;
	logic   [`RAW_RGB_PIX_W:0] g_sum;
	rgb_beat_t                beat_q;

	assign up_pix   = beat_i.line_first ? '0 : line_mem[beat_i.x];
	assign left_pix = (beat_i.x == '0) ? '0 : left_q;
	assign ul_pix   = (beat_i.line_first || beat_i.x == '0) ? '0 : up_q;

	// samples indexed by class offset from the current pixel
	assign samp[0] = beat_i.raw;
	assign samp[1] = left_pix;
	assign samp[2] = up_pix;
	assign samp[3] = ul_pix;

	// class of the current pixel where 0 is R and 3 is B
	assign cls = {beat_i.y_odd ^ phase_i[1], beat_i.x[0] ^ phase_i[0]};

	// the two G samples sit at class 1 and 2
	assign g_sum = {1'b0, samp[cls ^ 2'd1]} + {1'b0, samp[cls ^ 2'd2]};

	always_ff @(posedge aclk) begin
		if (cke_i && beat_i.valid) begin
			line_mem[beat_i.x] <= beat_i.raw;
			left_q             <= beat_i.raw;
			up_q               <= up_pix;
		end
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			beat_q.valid <= 1'b0;
		end else if (cke_i) begin
			beat_q.valid       <= beat_i.valid;
			beat_q.frame_start <= beat_i.frame_start;
			beat_q.line_last   <= beat_i.line_last;
			beat_q.raw         <= beat_i.raw;
			beat_q.r           <= samp[cls];
			beat_q.g           <= g_sum[`RAW_RGB_PIX_W:1];  // floor mean
			beat_q.b           <= samp[cls ^ 2'd3];
		end
	end

	assign beat_o = beat_q;

endmodule

// File: hdl/raw_rgb_color_matrix.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module raw_rgb_color_matrix
	import raw_rgb_pkg::*;
(
	input  logic       aclk,
	input  logic       arst_n_i,
	input  logic       cke_i,
	input  coeff_set_t coeffs_i,
	input  rgb_beat_t  beat_i,
	output rgb_beat_t  beat_o
);

	localparam int PROD_W = `RAW_RGB_COEFF_W + `RAW_RGB_PIX_W + 1;
	localparam int SUM_W  = PROD_W + 2;
	localparam int MAX_V  = (1 << `RAW_RGB_PIX_W) - 1;

	logic signed [PROD_W-1:0] prod_q [3][3];
	logic signed [SUM_W-1:0]  sum_q  [3];
	logic signed [SUM_W:0]    adj    [3];
	pixel_t                   pix_in [3];
	pixel_t                   clip   [3];
	rgb_beat_t                s1_q;
	rgb_beat_t                s2_q;
	rgb_beat_t                s3_q;

	assign pix_in[0] = beat_i.r;
	assign pix_in[1] = beat_i.g;
	assign pix_in[2] = beat_i.b;

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			adj[r] = (sum_q[r] >>> `RAW_RGB_FRAC_W) + $signed(coeffs_i.ofs[r]);
			if (adj[r] < 0)
				clip[r] = '0;
			else if (adj[r] > MAX_V)
				clip[r] = pixel_t'(MAX_V);
			else
				clip[r] = adj[r][`RAW_RGB_PIX_W-1:0];
		end
	end

	always_ff @(posedge aclk) begin
		if (cke_i) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					prod_q[r][c] <= $signed(coeffs_i.coef[r][c]) * $signed({1'b0, pix_in[c]});
				end
				sum_q[r] <= prod_q[r][0] + prod_q[r][1] + prod_q[r][2];  // row sum
			end
		end
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_q.valid <= 1'b0;
			s2_q.valid <= 1'b0;
			s3_q.valid <= 1'b0;
		end else if (cke_i) begin
			s1_q   <= beat_i;
			s2_q   <= s1_q;
			s3_q   <= s2_q;  // raw and flags ride along
			s3_q.r <= clip[0];
			s3_q.g <= clip[1];
			s3_q.b <= clip[2];
		end
	end

	assign beat_o = s3_q;

endmodule

// File: hdl/video_raw_to_rgb.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module video_raw_to_rgb
	import raw_rgb_pkg::*;
(
	input  logic                        aclk,
	input  logic                        arst_n_i,
	input  pixel_t                      s_tdata_i,
	input  logic                        s_tuser_i,
	input  logic                        s_tlast_i,
	input  logic                        s_tvalid_i,
	output logic                        s_tready_o,
	output logic [4*`RAW_RGB_PIX_W-1:0] m_tdata_o,
	output logic                        m_tuser_o,
	output logic                        m_tlast_o,
	output logic                        m_tvalid_o,
	input  logic                        m_tready_i,
	input  logic [`RAW_RGB_ADR_W-1:0]   reg_adr_i,
	input  reg_data_t                   reg_dat_i,
	input  logic                        reg_we_i,
	input  logic                        reg_stb_i,
	output reg_data_t                   reg_dat_o,
	output logic                        reg_ack_o
);

	logic       cke;
	phase_t     phase;
	coeff_set_t coeffs;
	raw_beat_t  raw_beat;
	rgb_beat_t  dem_beat;
	rgb_beat_t  out_beat;

	raw_rgb_regs u_regs (
		.aclk      (aclk),
		.arst_n_i  (arst_n_i),
		.reg_adr_i (reg_adr_i),
		.reg_dat_i (reg_dat_i),
		.reg_we_i  (reg_we_i),
		.reg_stb_i (reg_stb_i),
		.reg_dat_o (reg_dat_o),
		.reg_ack_o (reg_ack_o),
		.phase_o   (phase),
		.coeffs_o  (coeffs)
	);

	raw_rgb_stream_ctl u_stream_ctl (
		.aclk       (aclk),
		.arst_n_i   (arst_n_i),
		.s_tdata_i  (s_tdata_i),
		.s_tuser_i  (s_tuser_i),
		.s_tlast_i  (s_tlast_i),
		.s_tvalid_i (s_tvalid_i),
		.m_tvalid_i (out_beat.valid),
		.m_tready_i (m_tready_i),
		.s_tready_o (s_tready_o),
		.cke_o      (cke),
		.beat_o     (raw_beat)
	);

	raw_rgb_demosaic u_demosaic (
		.aclk     (aclk),
		.arst_n_i (arst_n_i),
		.cke_i    (cke),
		.phase_i  (phase),
		.beat_i   (raw_beat),
		.beat_o   (dem_beat)
	);

	raw_rgb_color_matrix u_color_matrix (
		.aclk     (aclk),
		.arst_n_i (arst_n_i),
		.cke_i    (cke),
		.coeffs_i (coeffs),
		.beat_i   (dem_beat),
		.beat_o   (out_beat)
	);

	assign m_tdata_o  = {out_beat.raw, out_beat.r, out_beat.g, out_beat.b};
	assign m_tuser_o  = out_beat.frame_start;
	assign m_tlast_o  = out_beat.line_last;
	assign m_tvalid_o = out_beat.valid;

endmodule

// File: testbench/raw_rgb_assertions.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module raw_rgb_assertions (
	input logic                        aclk,
	input logic                        arst_n_i,
	input logic                        s_tready_o,
	input logic [4*`RAW_RGB_PIX_W-1:0] m_tdata_o,
	input logic                        m_tuser_o,
	input logic                        m_tlast_o,
	input logic                        m_tvalid_o,
	input logic                        m_tready_i,
	input logic                        reg_stb_i,
	input logic                        reg_ack_o
);

	a_empty_after_reset: assert property (@(posedge aclk) !arst_n_i |=> !m_tvalid_o)
		else $error("m_tvalid_o high right after reset");

	// held beat must not change under back-pressure
	a_hold_stable: assert property (@(posedge aclk) disable iff (!arst_n_i)
		m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o)
			&& $stable(m_tuser_o) && $stable(m_tlast_o))
		else $error("output beat changed while stalled");

	a_ready_rule: assert property (@(posedge aclk) s_tready_o == (!m_tvalid_o || m_tready_i))
		else $error("s_tready_o does not follow the stall rule");

	a_ack_rule: assert property (@(posedge aclk) reg_ack_o == reg_stb_i)
		else $error("reg_ack_o differs from reg_stb_i");

endmodule

bind video_raw_to_rgb raw_rgb_assertions u_assertions (
	.aclk       (aclk),
	.arst_n_i   (arst_n_i),
	.s_tready_o (s_tready_o),
	.m_tdata_o  (m_tdata_o),
	.m_tuser_o  (m_tuser_o),
	.m_tlast_o  (m_tlast_o),
	.m_tvalid_o (m_tvalid_o),
	.m_tready_i (m_tready_i),
	.reg_stb_i  (reg_stb_i),
	.reg_ack_o  (reg_ack_o)
);

// File: testbench/tb_video_raw_to_rgb.sv
`timescale 1ns/1ps
`include "raw_rgb_defines.svh"

module tb_video_raw_to_rgb
	import raw_rgb_pkg::*;
();

	localparam int PW          = `RAW_RGB_PIX_W;
	localparam int PIX_MAX     = (1 << PW) - 1;
	localparam int FRAME_W     = 8;
	localparam int FRAME_H     = 6;
	localparam int DRV_DLY     = 2;
	localparam int TIMEOUT_CYC = 2500;  // 7 frames of 48 beats at up to 4 cycles plus setup and margin

	logic                      aclk;
	logic                      arst_n_i;
	pixel_t                    s_tdata_i;
	logic                      s_tuser_i;
	logic                      s_tlast_i;
	logic                      s_tvalid_i;
	logic                      s_tready_o;
	logic [4*PW-1:0]           m_tdata_o;
	logic                      m_tuser_o;
	logic                      m_tlast_o;
	logic                      m_tvalid_o;
	logic                      m_tready_i;
	logic [`RAW_RGB_ADR_W-1:0] reg_adr_i;
	reg_data_t                 reg_dat_i;
	logic                      reg_we_i;
	logic                      reg_stb_i;
	reg_data_t                 reg_dat_o;
	logic                      reg_ack_o;

	logic [15:0] stim_lfsr;
	logic [15:0] rdy_lfsr;
	logic        rdy_bit;
	logic        ready_gaps;
	logic        lat_armed;
	logic        verdict_shown;
	int          cyc;
	int          in_cyc;
	int          sat_lo;
	int          sat_hi;
	int          frame [FRAME_H][FRAME_W];
	int          coef_m [9];
	int          ofs_m [3];
	int          phase_m;
	int          cfg [13];
	logic [41:0] exp_q [$];  // tuser, tlast, raw, r, g, b
	logic [41:0] exp_beat;

	video_raw_to_rgb uut (.*);

	always #20 aclk = ~aclk;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic int next_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(stim_lfsr[0]);
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return v;
	endfunction

	// 2x2 demosaic then matrix, offset and clip for the pixel at (x, y)
	function automatic logic [4*PW-1:0] ref_pixel(input int x, input int y);
		int     win [4];
		int     col [3];
		int     cls;
		int     gsum;
		int     acc;
		pixel_t res [4];
		win[0] = frame[y][x];
		win[1] = (x > 0) ? frame[y][x-1] : 0;
		win[2] = (y > 0) ? frame[y-1][x] : 0;
		win[3] = (x > 0 && y > 0) ? frame[y-1][x-1] : 0;
		col[0] = 0;
		col[2] = 0;
		gsum   = 0;
		for (int k = 0; k < 4; k++) begin
			cls = ((((y - k / 2) & 1) ^ ((phase_m >> 1) & 1)) << 1)
				| (((x - k % 2) & 1) ^ (phase_m & 1));  // class of the sample's own site
			if (cls == 0)
				col[0] = win[k];
			else if (cls == 3)
				col[2] = win[k];
			else
				gsum += win[k];
		end
		col[1] = gsum / 2;
		res[0] = pixel_t'(win[0]);
		for (int r = 0; r < 3; r++) begin
			acc = coef_m[3*r] * col[0] + coef_m[3*r+1] * col[1] + coef_m[3*r+2] * col[2];
			acc = (acc >>> `RAW_RGB_FRAC_W) + ofs_m[r];
			res[r+1] = pixel_t'((acc < 0) ? 0 : ((acc > PIX_MAX) ? PIX_MAX : acc));
		end
		return {res[0], res[1], res[2], res[3]};
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		verdict_shown = 1'b1;
		$display("Testbench failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			fail_run("value mismatch");
		end
	endtask

	task automatic write_reg(input int adr, input int val);
		@(posedge aclk);
		#DRV_DLY;
		reg_adr_i = adr[`RAW_RGB_ADR_W-1:0];
		reg_dat_i = reg_data_t'(val);
		reg_we_i  = 1'b1;
		reg_stb_i = 1'b1;
		@(posedge aclk);
		#DRV_DLY;
		reg_stb_i = 1'b0;
		reg_we_i  = 1'b0;
		if (adr == `RAW_RGB_REG_PHASE)
			phase_m = val;
		else if (adr <= `RAW_RGB_REG_C22)
			coef_m[adr - `RAW_RGB_REG_C00] = val;
		else
			ofs_m[adr - `RAW_RGB_REG_OFS_R] = val;
	endtask

	task automatic read_reg(input int adr, input int exp_val);
		@(posedge aclk);
		#DRV_DLY;
		reg_adr_i = adr[`RAW_RGB_ADR_W-1:0];
		reg_we_i  = 1'b0;
		reg_stb_i = 1'b1;
		@(negedge aclk);
		check_value("reg_ack_o", reg_ack_o, 1);
		check_value("reg_dat_o", reg_dat_o, reg_data_t'(exp_val));
		@(posedge aclk);
		#DRV_DLY;
		reg_stb_i = 1'b0;
	endtask

	task automatic send_frame(input logic gaps);
		logic [4*PW-1:0] exp_data;
		logic            held_valid;
		for (int y = 0; y < FRAME_H; y++)
			for (int x = 0; x < FRAME_W; x++)
				frame[y][x] = next_bits(PW);
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < FRAME_W; x++) begin
				exp_data = ref_pixel(x, y);
				exp_q.push_back({x == 0 && y == 0, x == FRAME_W - 1, exp_data});
				for (int c = 0; c < 3; c++) begin
					sat_lo += (exp_data[c*PW +: PW] == 0) ? 1 : 0;
					sat_hi += (exp_data[c*PW +: PW] == PIX_MAX) ? 1 : 0;
				end
			end
		end
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < FRAME_W; x++) begin
				held_valid = 1'b0;
				do begin
					@(posedge aclk);
					#DRV_DLY;
					s_tvalid_i = !gaps || held_valid || (next_bits(2) != 0);  // 3 beats in 4 with gaps
					held_valid = s_tvalid_i;  // valid stays up until accepted
					s_tdata_i  = pixel_t'(frame[y][x]);
					s_tuser_i  = (x == 0 && y == 0);
					s_tlast_i  = (x == FRAME_W - 1);
					@(negedge aclk);
				end while (!(s_tvalid_i && s_tready_o));
			end
		end
		@(posedge aclk);
		#DRV_DLY;
		s_tvalid_i = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(posedge aclk);
		@(posedge aclk);
	endtask

	always @(posedge aclk) begin
		#DRV_DLY;
		if (ready_gaps) begin
			rdy_bit    = rdy_lfsr[0];
			rdy_lfsr   = lfsr_step(rdy_lfsr);
			m_tready_i = rdy_bit | rdy_lfsr[0];
			rdy_lfsr   = lfsr_step(rdy_lfsr);
		end else begin
			m_tready_i = 1'b1;
		end
	end

	always @(posedge aclk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC)
			fail_run("timeout, the tests did not complete within the cycle limit");
	end

	// compare on each output transfer sampled mid-cycle
	always @(negedge aclk) begin
		if (lat_armed && in_cyc < 0 && s_tvalid_i && s_tready_o)
			in_cyc = cyc;
		if (m_tvalid_o && m_tready_i) begin
			if (exp_q.size() == 0) begin
				fail_run("an output beat arrived with no beat expected");
			end else begin
				exp_beat = exp_q.pop_front();
				if (lat_armed) begin
					check_value("latency in clocks", cyc - in_cyc, 5);
					lat_armed = 1'b0;
				end
				check_value("m_tuser_o", m_tuser_o, exp_beat[41]);
				check_value("m_tlast_o", m_tlast_o, exp_beat[40]);
				check_value("m_tdata_o raw", m_tdata_o[3*PW +: PW], exp_beat[3*PW +: PW]);
				check_value("m_tdata_o r", m_tdata_o[2*PW +: PW], exp_beat[2*PW +: PW]);
				check_value("m_tdata_o g", m_tdata_o[PW +: PW], exp_beat[PW +: PW]);
				check_value("m_tdata_o b", m_tdata_o[0 +: PW], exp_beat[0 +: PW]);
			end
		end
	end

	final begin
		if (!verdict_shown)
			$display("Testbench failed");
	end

	initial begin
		aclk          = 1'b0;
		arst_n_i      = 1'b0;
		s_tdata_i     = '0;
		s_tuser_i     = 1'b0;
		s_tlast_i     = 1'b0;
		s_tvalid_i    = 1'b0;
		m_tready_i    = 1'b1;
		reg_adr_i     = '0;
		reg_dat_i     = '0;
		reg_we_i      = 1'b0;
		reg_stb_i     = 1'b0;
		stim_lfsr     = 16'd32861;
		rdy_lfsr      = 16'd32861;
		ready_gaps    = 1'b0;
		lat_armed     = 1'b0;
		verdict_shown = 1'b0;
		cyc           = 0;
		in_cyc        = -1;
		phase_m       = 0;
		for (int i = 0; i < 9; i++)
			coef_m[i] = (i % 4 == 0) ? 256 : 0;  // identity with 1.0 on the diagonal
		for (int i = 0; i < 3; i++)
			ofs_m[i] = 0;
		cfg = '{0, 512, -128, 37, -256, 300, 64, 77, -150, 400, 100, -50, -301};
		repeat (8) @(posedge aclk);
		#DRV_DLY;
		arst_n_i = 1'b1;

		// reset values and the unmapped addresses 13 to 15
		for (int a = 0; a < 16; a++)
			read_reg(a, (a >= `RAW_RGB_REG_C00 && a <= `RAW_RGB_REG_C22) ? coef_m[a - 1] : 0);

		lat_armed = 1'b1;
		send_frame(1'b0);
		wait_drain();
		for (int p = 1; p < 4; p++) begin
			write_reg(`RAW_RGB_REG_PHASE, p);
			send_frame(1'b0);
			wait_drain();
		end

		for (int a = 0; a < 13; a++)
			write_reg(a, cfg[a]);
		sat_lo = 0;
		sat_hi = 0;
		send_frame(1'b0);
		wait_drain();
		if (sat_lo == 0 || sat_hi == 0)
			fail_run("the matrix frame did not reach both clip limits");

		ready_gaps = 1'b1;
		send_frame(1'b1);
		send_frame(1'b1);
		wait_drain();
		ready_gaps = 1'b0;
		repeat (10) @(posedge aclk);
		verdict_shown = 1'b1;
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: files.f
+incdir+include
hdl/raw_rgb_pkg.sv
hdl/raw_rgb_regs.sv
hdl/raw_rgb_stream_ctl.sv
hdl/raw_rgb_demosaic.sv
hdl/raw_rgb_color_matrix.sv
hdl/video_raw_to_rgb.sv
testbench/raw_rgb_assertions.sv
testbench/tb_video_raw_to_rgb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_video_raw_to_rgb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi
